// File: include/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Word RAM window
`define RAM_BASE        32'h0000_1000
`define RAM_WORDS       256

// Keyboard register, last make code
`define KEY_ADDR        32'h0000_2000

// UART byte write
`define UART_ADDR       32'h0000_2004

// SD control and status registers
`define SD_ADDR_REG     32'h0000_2008
`define SD_READ_REG     32'h0000_200C
`define SD_AVAIL_REG    32'h0000_2010

// Sector cache window, one byte per address
`define SD_CACHE_BASE   32'h0000_3000
`define SECTOR_BYTES    512

// PS/2 break prefix
`define PS2_BREAK       8'hF0

`endif

// File: src/soc_pkg.sv
package soc_pkg;

    // Decoded bus target
    typedef enum logic [2:0] {
        TGT_RAM,
        TGT_KEY,
        TGT_UART,
        TGT_SD_ADDR,
        TGT_SD_READ,
        TGT_SD_AVAIL,
        TGT_SD_CACHE,
        TGT_NONE
    } bus_target_e;

    // PS/2 frame receiver
    typedef enum logic {
        PS_IDLE,
        PS_SHIFT
    } ps2_state_e;

    // Sector fill handshake
    typedef enum logic [1:0] {
        FS_IDLE,
        FS_FILL,
        FS_RELEASE
    } fill_state_e;

endpackage

// File: src/ps2_receiver.sv
`include "soc_params.svh"

module ps2_receiver (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] scan_code,
    output logic       key_pressed,
    output logic       key_released
);

    soc_pkg::ps2_state_e state;
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       clk_fall;
    logic [3:0] bit_cnt;
    logic [9:0] shift;
    logic [9:0] frame;
    logic       frame_ok;
    logic       break_seen;

    // Both lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev && !clk_sync[1];

    // Frame after the current bit is shifted in, LSB first
    assign frame = {dat_sync[1], shift[9:1]};
    // Stop bit high and odd parity over data plus parity
    assign frame_ok = frame[9] && (^frame[8:0]);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state        <= soc_pkg::PS_IDLE;
            bit_cnt      <= '0;
            shift        <= '0;
            break_seen   <= 1'b0;
            scan_code    <= '0;
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
        end else begin
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
            if (clk_fall) begin
                case (state)
                    soc_pkg::PS_IDLE: begin
                        // Start bit must be low
                        if (!dat_sync[1]) begin
                            state   <= soc_pkg::PS_SHIFT;
                            bit_cnt <= '0;
                        end
                    end
                    soc_pkg::PS_SHIFT: begin
                        shift <= frame;
                        if (bit_cnt == 4'd9) begin
                            state <= soc_pkg::PS_IDLE;
                            if (frame_ok) begin
                                if (frame[7:0] == `PS2_BREAK) begin
                                    break_seen <= 1'b1;
                                end else begin
                                    scan_code    <= frame[7:0];
                                    key_pressed  <= !break_seen;
                                    key_released <= break_seen;
                                    break_seen   <= 1'b0;
                                end
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                    default: state <= soc_pkg::PS_IDLE;
                endcase
            end
        end
    end

endmodule

// File: src/irq_ctrl.sv
module irq_ctrl (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       key_pressed,
    input  logic       irq_ack,
    output logic [3:0] irq_vector
);

    logic pending;
    logic clear;

    assign pending = (irq_vector != 4'd0);
    assign clear   = irq_ack && pending;

    // Keyboard is vector 1; acknowledge beats a new press
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_vector <= 4'd0;
        end else if (clear) begin
            irq_vector <= 4'd0;
        end else if (key_pressed) begin
            irq_vector <= 4'd1;
        end
    end

endmodule

// File: src/sector_cache.sv
`include "soc_params.svh"

module sector_cache (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       fill_start,
    output logic       sd_req,
    input  logic       sd_ack,
    input  logic [7:0] sd_byte,
    input  logic       sd_byte_valid,
    input  logic [8:0] cache_index,
    output logic [7:0] cache_byte,
    output logic       cache_available
);

    localparam int IDX_W = $clog2(`SECTOR_BYTES);

    soc_pkg::fill_state_e state;
    logic [IDX_W-1:0] fill_index;
    logic [7:0]       buffer [0:`SECTOR_BYTES-1];
    logic             store;

    assign store = (state == soc_pkg::FS_FILL) && sd_byte_valid;

    // Four-phase request toward the SD source
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state           <= soc_pkg::FS_IDLE;
            fill_index      <= '0;
            sd_req          <= 1'b0;
            cache_available <= 1'b0;
        end else begin
            case (state)
                soc_pkg::FS_IDLE: begin
                    if (fill_start) begin
                        state           <= soc_pkg::FS_FILL;
                        fill_index      <= '0;
                        sd_req          <= 1'b1;
                        cache_available <= 1'b0;
                    end
                end
                soc_pkg::FS_FILL: begin
                    if (store) begin
                        fill_index <= fill_index + 1'b1;
                    end
                    if (sd_ack) begin
                        state  <= soc_pkg::FS_RELEASE;
                        sd_req <= 1'b0;
                    end
                end
                soc_pkg::FS_RELEASE: begin
                    // Wait for the source to drop ack
                    if (!sd_ack) begin
                        state           <= soc_pkg::FS_IDLE;
                        cache_available <= 1'b1;
                    end
                end
                default: state <= soc_pkg::FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (store) begin
            buffer[fill_index] <= sd_byte;
        end
    end

    assign cache_byte = buffer[cache_index];

endmodule

// File: src/bus_fabric.sv
`include "soc_params.svh"

module bus_fabric (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic [31:0] bus_address,
    input  logic [31:0] bus_write_data,
    input  logic        bus_write_enable,
    input  logic        bus_read_enable,
    output logic [31:0] bus_read_data,
    output logic        bus_read_done,
    input  logic [7:0]  scan_code,
    input  logic        key_pressed,
    output logic [7:0]  uart_data,
    output logic        uart_wr,
    output logic [31:0] sd_addr,
    output logic        fill_start,
    input  logic        cache_available,
    output logic [8:0]  cache_index,
    input  logic [7:0]  cache_byte
);

    localparam int RAM_AW = $clog2(`RAM_WORDS);

    soc_pkg::bus_target_e target;
    logic [31:0]       ram_offset;
    logic [31:0]       cache_offset;
    logic [RAM_AW-1:0] ram_index;
    logic [31:0]       ram [0:`RAM_WORDS-1];
    logic [31:0]       read_mux;
    logic [7:0]        key_reg;
    logic              read_accept;
    logic              uart_sel;
    logic              uart_sel_d;
    logic              uart_edge;

    assign ram_offset   = bus_address - `RAM_BASE;
    assign cache_offset = bus_address - `SD_CACHE_BASE;
    assign ram_index    = ram_offset[RAM_AW+1:2];
    assign cache_index  = cache_offset[8:0];

    // Address decode
    always_comb begin
        if (bus_address >= `RAM_BASE && bus_address < `RAM_BASE + 4 * `RAM_WORDS) begin
            target = soc_pkg::TGT_RAM;
        end else if (bus_address == `KEY_ADDR) begin
            target = soc_pkg::TGT_KEY;
        end else if (bus_address == `UART_ADDR) begin
            target = soc_pkg::TGT_UART;
        end else if (bus_address == `SD_ADDR_REG) begin
            target = soc_pkg::TGT_SD_ADDR;
        end else if (bus_address == `SD_READ_REG) begin
            target = soc_pkg::TGT_SD_READ;
        end else if (bus_address == `SD_AVAIL_REG) begin
            target = soc_pkg::TGT_SD_AVAIL;
        end else if (bus_address >= `SD_CACHE_BASE &&
                     bus_address < `SD_CACHE_BASE + `SECTOR_BYTES) begin
            target = soc_pkg::TGT_SD_CACHE;
        end else begin
            target = soc_pkg::TGT_NONE;
        end
    end

    // Unmapped and write-only targets read as zero
    always_comb begin
        case (target)
            soc_pkg::TGT_RAM:      read_mux = ram[ram_index];
            soc_pkg::TGT_KEY:      read_mux = {24'd0, key_reg};
            soc_pkg::TGT_SD_ADDR:  read_mux = sd_addr;
            soc_pkg::TGT_SD_AVAIL: read_mux = {31'd0, cache_available};
            soc_pkg::TGT_SD_CACHE: read_mux = {24'd0, cache_byte};
            default:               read_mux = 32'd0;
        endcase
    end

    // Enable is ignored during the done cycle
    assign read_accept = bus_read_enable && !bus_read_done;

    assign uart_sel  = bus_write_enable && (target == soc_pkg::TGT_UART);
    assign uart_edge = uart_sel && !uart_sel_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b0;
            key_reg       <= '0;
            sd_addr       <= '0;
            fill_start    <= 1'b0;
            uart_sel_d    <= 1'b0;
            uart_wr       <= 1'b0;
        end else begin
            bus_read_done <= read_accept;
            fill_start    <= bus_write_enable && (target == soc_pkg::TGT_SD_READ);
            uart_sel_d    <= uart_sel;
            uart_wr       <= uart_edge;
            if (key_pressed) begin
                key_reg <= scan_code;
            end
            if (bus_write_enable && target == soc_pkg::TGT_SD_ADDR) begin
                sd_addr <= bus_write_data;
            end
        end
    end

    // RAM port and read data
    always_ff @(posedge CLOCK_50) begin
        if (bus_write_enable && target == soc_pkg::TGT_RAM) begin
            ram[ram_index] <= bus_write_data;
        end
        if (read_accept) begin
            bus_read_data <= read_mux;
        end
        if (uart_edge) begin
            uart_data <= bus_write_data[7:0];
        end
    end

endmodule

// File: src/soc_top.sv
module soc_top (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic [31:0] bus_address,
    input  logic [31:0] bus_write_data,
    input  logic        bus_write_enable,
    input  logic        bus_read_enable,
    output logic [31:0] bus_read_data,
    output logic        bus_read_done,
    output logic [3:0]  irq_vector,
    input  logic        irq_ack,
    input  logic        ps2_clk,
    input  logic        ps2_dat,
    output logic [7:0]  uart_data,
    output logic        uart_wr,
    output logic [31:0] sd_addr,
    output logic        sd_req,
    input  logic        sd_ack,
    input  logic [7:0]  sd_byte,
    input  logic        sd_byte_valid
);

    logic [7:0] scan_code;
    logic       key_pressed;
    logic       fill_start;
    logic       cache_available;
    logic [8:0] cache_index;
    logic [7:0] cache_byte;

    bus_fabric u_bus_fabric (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .scan_code        (scan_code),
        .key_pressed      (key_pressed),
        .uart_data        (uart_data),
        .uart_wr          (uart_wr),
        .sd_addr          (sd_addr),
        .fill_start       (fill_start),
        .cache_available  (cache_available),
        .cache_index      (cache_index),
        .cache_byte       (cache_byte)
    );

    // Break codes are decoded but raise nothing here
    ps2_receiver u_ps2_receiver (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .ps2_clk      (ps2_clk),
        .ps2_dat      (ps2_dat),
        .scan_code    (scan_code),
        .key_pressed  (key_pressed),
        .key_released ()
    );

    irq_ctrl u_irq_ctrl (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_pressed (key_pressed),
        .irq_ack     (irq_ack),
        .irq_vector  (irq_vector)
    );

    sector_cache u_sector_cache (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .fill_start      (fill_start),
        .sd_req          (sd_req),
        .sd_ack          (sd_ack),
        .sd_byte         (sd_byte),
        .sd_byte_valid   (sd_byte_valid),
        .cache_index     (cache_index),
        .cache_byte      (cache_byte),
        .cache_available (cache_available)
    );

endmodule

// File: test/soc_asserts.sv
module soc_asserts (
    input logic CLOCK_50,
    input logic KEY0,
    input logic bus_read_done,
    input logic uart_wr,
    input logic sd_req,
    input logic sd_ack,
    input logic cache_available
);

    // Read done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_done |=> !bus_read_done)
        else $error("bus_read_done high for two cycles running");

    uart_one_cycle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_wr |=> !uart_wr)
        else $error("uart_wr high for more than one cycle");

    // Request holds until the source acknowledges
    req_until_ack: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (sd_req && !sd_ack) |=> sd_req)
        else $error("sd_req dropped before sd_ack");

    avail_low_in_fill: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_req |-> !cache_available)
        else $error("cache_available high while sd_req is high");

endmodule

// File: test/tb_soc.sv
`include "soc_params.svh"

module tb_soc;

    localparam int TIMEOUT   = 2000;
    localparam int PS2_HALF  = 4;
    localparam int AVAIL_TRY = 50;

    typedef enum {
        OP_RAM_WR,
        OP_RAM_RD,
        OP_READ,
        OP_HOLD,
        OP_KEY,
        OP_ACK,
        OP_UART,
        OP_FILL,
        OP_CACHE
    } op_e;

    typedef struct {
        op_e         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        string       name;
    } row_t;

    logic        CLOCK_50;
    logic        KEY0;
    logic [31:0] bus_address;
    logic [31:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    logic [31:0] bus_read_data;
    logic        bus_read_done;
    logic [3:0]  irq_vector;
    logic        irq_ack;
    logic        ps2_clk;
    logic        ps2_dat;
    logic [7:0]  uart_data;
    logic        uart_wr;
    logic [31:0] sd_addr;
    logic        sd_req;
    logic        sd_ack;
    logic [7:0]  sd_byte;
    logic        sd_byte_valid;

    row_t        stim_q[$];
    logic [15:0] lfsr_state;
    logic [31:0] ram_model [0:`RAM_WORDS-1];
    logic [7:0]  cache_model [0:`SECTOR_BYTES-1];
    int          uart_count;
    logic [7:0]  uart_last;

    soc_top u_soc_top (.*);

    bind soc_top soc_asserts u_soc_asserts (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_read_done   (bus_read_done),
        .uart_wr         (uart_wr),
        .sd_req          (sd_req),
        .sd_ack          (sd_ack),
        .cache_available (cache_available)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    // UART strobe monitor
    always @(negedge CLOCK_50) begin
        if (uart_wr) begin
            uart_count <= uart_count + 1;
            uart_last  <= uart_data;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Regression failed");
        $fatal(1, "Timeout");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic void add_row(input op_e op, input logic [31:0] addr,
                                    input logic [31:0] data, input logic [31:0] expected,
                                    input string name);
        row_t r;
        r.op       = op;
        r.addr     = addr;
        r.data     = data;
        r.expected = expected;
        r.name     = name;
        stim_q.push_back(r);
    endfunction

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        @(negedge CLOCK_50);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
    endtask

    // Done is expected one cycle after enable is sampled
    task automatic read_word(input logic [31:0] addr, input string name,
                             output logic [31:0] data);
        int cycles;
        @(negedge CLOCK_50);
        bus_address     = addr;
        bus_read_enable = 1'b1;
        cycles = 0;
        do begin
            @(negedge CLOCK_50);
            cycles++;
        end while (!bus_read_done && cycles < TIMEOUT);
        if (!bus_read_done) fail_timeout("bus_read_done");
        check_value({name, " latency"}, 32'd1, cycles);
        data = bus_read_data;
        bus_read_enable = 1'b0;
    endtask

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic send_ps2_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        logic        parity;
        parity = ~^code;
        if (bad_parity) parity = ~parity;
        frame = {1'b1, parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(negedge CLOCK_50);
            ps2_dat = frame[i];
            repeat (PS2_HALF) @(negedge CLOCK_50);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge CLOCK_50);
            ps2_clk = 1'b1;
        end
        repeat (PS2_HALF) @(negedge CLOCK_50);
    endtask

    task automatic pulse_ack();
        @(negedge CLOCK_50);
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
    endtask

    task automatic wait_sd_req(input logic level);
        int cycles;
        cycles = 0;
        while (sd_req !== level && cycles < TIMEOUT) begin
            @(negedge CLOCK_50);
            cycles++;
        end
        if (sd_req !== level) fail_timeout("sd_req");
    endtask

    task automatic check_uart(input row_t row);
        int start;
        int cycles;
        start = uart_count;
        // Enable held for several cycles still gives one strobe
        @(negedge CLOCK_50);
        bus_address      = row.addr;
        bus_write_data   = row.data;
        bus_write_enable = 1'b1;
        repeat (3) @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        cycles = 0;
        while (uart_count == start && cycles < TIMEOUT) begin
            @(negedge CLOCK_50);
            cycles++;
        end
        if (uart_count == start) fail_timeout("uart_wr");
        repeat (4) @(negedge CLOCK_50);
        check_value({row.name, " strobes"}, 32'd1, uart_count - start);
        check_value(row.name, row.expected, {24'd0, uart_last});
    endtask

    task automatic run_fill(input row_t row);
        logic [31:0] rdata;
        logic [31:0] bits;
        int          tries;
        write_word(`SD_ADDR_REG, row.data);
        write_word(`SD_READ_REG, 32'd1);
        wait_sd_req(1'b1);
        check_value({row.name, " sd_addr"}, row.data, sd_addr);
        read_word(`SD_AVAIL_REG, row.name, rdata);
        check_value({row.name, " pending"}, 32'd0, rdata);
        for (int i = 0; i < `SECTOR_BYTES; i++) begin
            bits = take_bits(8);
            cache_model[i] = bits[7:0];
            @(negedge CLOCK_50);
            sd_byte       = bits[7:0];
            sd_byte_valid = 1'b1;
            @(negedge CLOCK_50);
            sd_byte_valid = 1'b0;
        end
        @(negedge CLOCK_50);
        sd_ack = 1'b1;
        wait_sd_req(1'b0);
        @(negedge CLOCK_50);
        sd_ack = 1'b0;
        // Poll the status register until the fill ends
        tries = 0;
        rdata = 32'd0;
        while (rdata[0] !== 1'b1 && tries < AVAIL_TRY) begin
            read_word(`SD_AVAIL_REG, row.name, rdata);
            tries++;
        end
        if (rdata[0] !== 1'b1) fail_timeout("cache available");
    endtask

    task automatic check_cache(input row_t row);
        logic [31:0] rdata;
        for (int i = 0; i < `SECTOR_BYTES; i++) begin
            read_word(`SD_CACHE_BASE + i, row.name, rdata);
            check_value(row.name, {24'd0, cache_model[i]}, rdata);
        end
    endtask

    task automatic load_table();
        add_row(OP_RAM_WR, `RAM_BASE,          0, 0, "ram write first");
        add_row(OP_RAM_WR, `RAM_BASE + 32'h4,  0, 0, "ram write second");
        add_row(OP_RAM_WR, `RAM_BASE + 32'h100, 0, 0, "ram write middle");
        add_row(OP_RAM_WR, `RAM_BASE + 32'h3FC, 0, 0, "ram write last");
        add_row(OP_RAM_RD, `RAM_BASE + 32'h3FC, 0, 0, "ram read last");
        add_row(OP_RAM_RD, `RAM_BASE,          0, 0, "ram read first");
        add_row(OP_RAM_RD, `RAM_BASE + 32'h100, 0, 0, "ram read middle");
        add_row(OP_RAM_RD, `RAM_BASE + 32'h4,  0, 0, "ram read second");
        // Bit 8 of data corrupts the parity bit
        add_row(OP_KEY,  0, 32'h01C, 32'd1, "key make irq");
        add_row(OP_READ, `KEY_ADDR, 0, 32'h1C, "key register");
        add_row(OP_ACK,  0, 0, 32'd0, "irq ack");
        add_row(OP_KEY,  0, 32'h0F0, 32'd0, "break prefix");
        add_row(OP_KEY,  0, 32'h01C, 32'd0, "key release");
        add_row(OP_KEY,  0, 32'h132, 32'd0, "bad parity");
        add_row(OP_READ, `KEY_ADDR, 0, 32'h1C, "key unchanged");
        add_row(OP_HOLD, `KEY_ADDR, 0, 32'h1C, "read enable held");
        add_row(OP_UART, `UART_ADDR, 32'hABCD_1234, 32'h34, "uart byte");
        add_row(OP_READ, 32'h0000_4000, 0, 32'd0, "unmapped read");
        add_row(OP_FILL, 0, 32'h0000_0042, 0, "sector fill");
        add_row(OP_READ, `SD_AVAIL_REG, 0, 32'd1, "cache available");
        add_row(OP_CACHE, 0, 0, 0, "cache bytes");
        // Refill while the cache is available
        add_row(OP_FILL, 0, 32'h0001_0ACE, 0, "second sector fill");
        add_row(OP_READ, `SD_AVAIL_REG, 0, 32'd1, "cache available again");
        add_row(OP_CACHE, 0, 0, 0, "second cache bytes");
    endtask

    initial begin
        row_t        row;
        logic [31:0] rdata;
        int          idx;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        irq_ack          = 1'b0;
        ps2_clk          = 1'b1;
        ps2_dat          = 1'b1;
        sd_ack           = 1'b0;
        sd_byte          = '0;
        sd_byte_valid    = 1'b0;
        uart_count       = 0;
        uart_last        = '0;
        lfsr_state       = 16'd6583;
        load_table();
        repeat (5) @(negedge CLOCK_50);
        KEY0 = 1'b1;

        foreach (stim_q[i]) begin
            row = stim_q[i];
            idx = (row.addr - `RAM_BASE) >> 2;
            case (row.op)
                OP_RAM_WR: begin
                    ram_model[idx] = take_bits(32);
                    write_word(row.addr, ram_model[idx]);
                end
                OP_RAM_RD: begin
                    read_word(row.addr, row.name, rdata);
                    check_value(row.name, ram_model[idx], rdata);
                end
                OP_READ: begin
                    read_word(row.addr, row.name, rdata);
                    check_value(row.name, row.expected, rdata);
                end
                OP_HOLD: begin
                    // Enable left high across the done edge
                    read_word(row.addr, row.name, rdata);
                    bus_read_enable = 1'b1;
                    @(negedge CLOCK_50);
                    bus_read_enable = 1'b0;
                    check_value({row.name, " done"}, 32'd0, {31'd0, bus_read_done});
                    check_value(row.name, row.expected, rdata);
                end
                OP_KEY: begin
                    send_ps2_frame(row.data[7:0], row.data[8]);
                    check_value(row.name, row.expected, {28'd0, irq_vector});
                end
                OP_ACK: begin
                    pulse_ack();
                    check_value(row.name, row.expected, {28'd0, irq_vector});
                end
                OP_UART:  check_uart(row);
                OP_FILL:  run_fill(row);
                OP_CACHE: check_cache(row);
                default: ;
            endcase
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// File: src.f
+incdir+include
src/soc_pkg.sv
src/ps2_receiver.sv
src/irq_ctrl.sv
src/sector_cache.sv
src/bus_fabric.sv
src/soc_top.sv
test/soc_asserts.sv
test/tb_soc.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_soc
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	$(SIM) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
